//--- soc_io_pkg.sv
`default_nettype none

package soc_io_pkg;

	// ------------------------------
	// bus structs
	// ------------------------------

	// request held stable by the requester until ack
	typedef struct packed {
		logic        cyc;
		logic        we;
		logic [3:0]  sel;
		logic [7:0]  tid;
		logic [31:0] padr;
		logic [31:0] data;
	} bus_req_t;

	// one-cycle response, all fields zero when idle
	typedef struct packed {
		logic        ack;
		logic        err;
		logic [7:0]  tid;
		logic [31:0] dat;
	} bus_resp_t;

	// responder channels
	typedef enum logic [2:0] {
		CH_NONE,
		CH_SCRATCH,
		CH_IOREG,
		CH_CONFIG,
		CH_UNMAPPED
	} io_chan_e;

	// ------------------------------
	// address map
	// ------------------------------

	// padr[31:24]
	localparam logic [7:0] SCRATCH_PAGE = 8'hFF;
	// padr[31:8]
	localparam logic [23:0] IOREG_PAGE = 24'hFEDFFF;
	// padr[31:28]
	localparam logic [3:0] CONFIG_NIBBLE = 4'hD;

	// register offsets inside the io page
	localparam logic [7:0] IOREG_LED_OFS = 8'h00;
	localparam logic [7:0] IOREG_RST_OFS = 8'h04;
	localparam logic [7:0] IOREG_TICK_OFS = 8'h08;

	// data returned when nothing answers in config space
	localparam logic [31:0] CONFIG_FILL = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

//--- io_addr_decode.sv
`default_nettype none

module io_addr_decode (
	input  wire logic                 node_clk,
	input  wire logic                 rst,
	input  wire soc_io_pkg::bus_req_t req_i,
	output logic                      scr_start_o,
	output logic                      ioreg_start_o,
	output logic                      cfg_start_o,
	output logic                      unmapped_start_o
);
	import soc_io_pkg::*;

	logic     cyc_q;
	logic     new_req;
	io_chan_e chan;

	// cyc rising edge marks a new request
	assign new_req = req_i.cyc & ~cyc_q;

	// ------------------------------
	// address decode
	// ------------------------------

	// priority scratch > io regs > config > unmapped
	always_comb begin
		chan = CH_NONE;
		if (new_req) begin
			if (req_i.padr[31:24] == SCRATCH_PAGE)
				chan = CH_SCRATCH;
			else if (req_i.padr[31:8] == IOREG_PAGE)
				chan = CH_IOREG;
			else if (req_i.padr[31:28] == CONFIG_NIBBLE)
				chan = CH_CONFIG;
			else
				chan = CH_UNMAPPED;
		end
	end

	// strobes registered, one cycle after cyc rises
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			cyc_q <= 1'b0;
			scr_start_o <= 1'b0;
			ioreg_start_o <= 1'b0;
			cfg_start_o <= 1'b0;
			unmapped_start_o <= 1'b0;
		end else begin
			cyc_q <= req_i.cyc;
			scr_start_o <= (chan == CH_SCRATCH);
			ioreg_start_o <= (chan == CH_IOREG);
			cfg_start_o <= (chan == CH_CONFIG);
			unmapped_start_o <= (chan == CH_UNMAPPED);
		end
	end

	// only one responder may be started per cycle
	a_one_start: assert property (@(posedge node_clk) disable iff (rst)
		$onehot0({scr_start_o, ioreg_start_o, cfg_start_o, unmapped_start_o}));

endmodule

`default_nettype wire

//--- scratch_ram.sv
`default_nettype none

module scratch_ram #(
	parameter int SCRATCH_WORDS = 256
) (
	input  wire logic                 node_clk,
	input  wire logic                 rst,
	input  wire logic                 start_i,
	input  wire soc_io_pkg::bus_req_t req_i,
	output soc_io_pkg::bus_resp_t     resp_o
);
	import soc_io_pkg::*;

	// word index width, depth taken as a power of two
	localparam int AW = $clog2(SCRATCH_WORDS);

	logic [31:0] mem [SCRATCH_WORDS];

	// stage 1, request captured on start
	logic          s1_vld;
	logic          s1_we;
	logic [3:0]    s1_sel;
	logic [AW-1:0] s1_idx;
	logic [31:0]   s1_data;
	logic [7:0]    s1_tid;

	// stage 2, array accessed
	logic          s2_vld;
	logic          s2_we;
	logic [7:0]    s2_tid;
	logic [31:0]   s2_rdata;

	// ------------------------------
	// pipeline valids
	// ------------------------------

	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
		end else begin
			s1_vld <= start_i;
			s2_vld <= s1_vld;
		end
	end

	// address bits above the byte offset, wraps at the depth
	always_ff @(posedge node_clk) begin
		if (start_i) begin
			s1_we <= req_i.we;
			s1_sel <= req_i.sel;
			s1_idx <= req_i.padr[2 +: AW];
			s1_data <= req_i.data;
			s1_tid <= req_i.tid;
		end
	end

	// ------------------------------
	// array access
	// ------------------------------

	// read returns the old word, write merges selected bytes
	always_ff @(posedge node_clk) begin
		if (s1_vld) begin
			s2_we <= s1_we;
			s2_tid <= s1_tid;
			s2_rdata <= mem[s1_idx];
			for (int b = 0; b < 4; b++) begin
				if (s1_we && s1_sel[b])
					mem[s1_idx][8*b +: 8] <= s1_data[8*b +: 8];
			end
		end
	end

	// zero when idle so the merge can OR channels
	always_comb begin
		resp_o = '0;
		if (s2_vld) begin
			resp_o.ack = 1'b1;
			resp_o.tid = s2_tid;
			// writes return no data
			resp_o.dat = s2_we ? 32'd0 : s2_rdata;
		end
	end

endmodule

`default_nettype wire

//--- io_regs.sv
`default_nettype none

module io_regs #(
	parameter int RST_PULSE_CYCLES = 64,
	parameter int TICK_DEFAULT = 200
) (
	input  wire logic                 node_clk,
	input  wire logic                 rst,
	input  wire logic                 start_i,
	input  wire soc_io_pkg::bus_req_t req_i,
	output soc_io_pkg::bus_resp_t     resp_o,
	output logic [7:0]                led_o,
	output logic [15:0]               rsts_o,
	output logic [15:0]               tick_period_o,
	output logic                      reload_o
);
	import soc_io_pkg::*;

	localparam int CW = $clog2(RST_PULSE_CYCLES + 1);

	logic [7:0]    ofs;
	logic          wr_led;
	logic          wr_rst;
	logic          wr_tick;
	logic [31:0]   rdat;
	logic [15:0]   tick_period_q;
	logic [15:0]   rst_val;
	logic          rst_pend;
	logic [CW-1:0] rst_cnt;
	logic          ack_q;
	logic [7:0]    tid_q;
	logic [31:0]   rdat_q;

	assign ofs = req_i.padr[7:0];
	// led is one byte, rst and tick take the low half
	assign wr_led = start_i & req_i.we & (ofs == IOREG_LED_OFS) & req_i.sel[0];
	assign wr_rst = start_i & req_i.we & (ofs == IOREG_RST_OFS) & (|req_i.sel[1:0]);
	assign wr_tick = start_i & req_i.we & (ofs == IOREG_TICK_OFS) & (|req_i.sel[1:0]);

	// readback mux, reset register and holes read zero
	always_comb begin
		rdat = '0;
		case (ofs)
			IOREG_LED_OFS: rdat[7:0] = led_o;
			IOREG_TICK_OFS: rdat[15:0] = tick_period_q;
			default: rdat = '0;
		endcase
	end

	// ------------------------------
	// registers
	// ------------------------------

	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			led_o <= '0;
			tick_period_q <= 16'(TICK_DEFAULT);
			reload_o <= 1'b0;
			rst_pend <= 1'b0;
			rst_cnt <= '0;
			rsts_o <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= start_i;
			reload_o <= wr_tick;
			// pulse starts the cycle after the ack
			rst_pend <= wr_rst;
			if (wr_led)
				led_o <= req_i.data[7:0];
			// period of zero would stall the timer, bump to one
			if (wr_tick)
				tick_period_q <= (req_i.data[15:0] == 16'd0) ? 16'd1 : req_i.data[15:0];
			// pulse countdown
			if (rst_cnt != '0) begin
				rst_cnt <= rst_cnt - 1'b1;
				if (rst_cnt == CW'(1))
					rsts_o <= '0;
			end
			// a new write restarts the pulse
			if (rst_pend) begin
				rsts_o <= rst_val;
				rst_cnt <= CW'(RST_PULSE_CYCLES);
			end
		end
	end

	always_ff @(posedge node_clk) begin
		if (wr_rst)
			rst_val <= req_i.data[15:0];
		if (start_i) begin
			tid_q <= req_i.tid;
			rdat_q <= req_i.we ? 32'd0 : rdat;
		end
	end

	assign tick_period_o = tick_period_q;

	// zero when idle so the merge can OR channels
	always_comb begin
		resp_o = '0;
		resp_o.ack = ack_q;
		if (ack_q) begin
			resp_o.tid = tid_q;
			resp_o.dat = rdat_q;
		end
	end

	a_tick_nonzero: assert property (@(posedge node_clk) disable iff (rst)
		tick_period_q != 16'd0);

endmodule

`default_nettype wire

//--- tick_timer.sv
`default_nettype none

module tick_timer (
	input  wire logic        node_clk,
	input  wire logic        rst,
	input  wire logic [15:0] tick_period_i,
	input  wire logic        reload_i,
	output logic             tick_irq_o
);

	// counts 1..period
	logic [15:0] cnt;
	logic [15:0] cnt_d;

	// ------------------------------
	// next count
	// ------------------------------

	// reload or wrap restarts at one
	// greater-or-equal covers a period shrinking below the count
	always_comb begin
		if (reload_i || cnt >= tick_period_i)
			cnt_d = 16'd1;
		else
			cnt_d = cnt + 16'd1;
	end

	// irq high while the count sits at the period
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
			tick_irq_o <= 1'b0;
		end else begin
			cnt <= cnt_d;
			tick_irq_o <= (cnt_d == tick_period_i);
		end
	end

endmodule

`default_nettype wire

//--- resp_merge.sv
`default_nettype none

module resp_merge #(
	parameter int TIMEOUT_CYCLES = 16
) (
	input  wire logic                  node_clk,
	input  wire logic                  rst,
	input  wire soc_io_pkg::bus_req_t  req_i,
	input  wire soc_io_pkg::bus_resp_t scr_resp_i,
	input  wire soc_io_pkg::bus_resp_t ioreg_resp_i,
	input  wire logic                  cfg_start_i,
	input  wire logic                  unmapped_start_i,
	output soc_io_pkg::bus_resp_t      resp_o
);
	import soc_io_pkg::*;

	localparam int CW = $clog2(TIMEOUT_CYCLES + 1);

	logic          cfg_busy;
	logic [CW-1:0] cfg_cnt;
	logic          cfg_ack;
	logic          unm_ack;
	bus_resp_t     cfg_resp;
	bus_resp_t     unm_resp;
	bus_resp_t     merged;
	logic          ack_q;
	logic          err_q;
	logic [7:0]    tid_q;
	logic [31:0]   dat_q;

	// ------------------------------
	// config timeout
	// ------------------------------

	// ack lands TIMEOUT_CYCLES after the start
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			cfg_busy <= 1'b0;
			cfg_cnt <= '0;
			unm_ack <= 1'b0;
		end else begin
			unm_ack <= unmapped_start_i;
			if (cfg_start_i) begin
				cfg_busy <= 1'b1;
				cfg_cnt <= CW'(TIMEOUT_CYCLES - 1);
			end else if (cfg_ack)
				cfg_busy <= 1'b0;
			else if (cfg_busy)
				cfg_cnt <= cfg_cnt - 1'b1;
		end
	end

	assign cfg_ack = cfg_busy && (cfg_cnt == '0);

	// tid comes from the held request
	always_comb begin
		cfg_resp = '0;
		unm_resp = '0;
		if (cfg_ack) begin
			cfg_resp.ack = 1'b1;
			cfg_resp.tid = req_i.tid;
			cfg_resp.dat = CONFIG_FILL;
		end
		// bus error
		if (unm_ack) begin
			unm_resp.ack = 1'b1;
			unm_resp.err = 1'b1;
			unm_resp.tid = req_i.tid;
		end
	end

	// ------------------------------
	// merge and register
	// ------------------------------

	// idle channels are all zero
	assign merged = scr_resp_i | ioreg_resp_i | cfg_resp | unm_resp;

	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= merged.ack;
			err_q <= merged.err;
		end
	end

	always_ff @(posedge node_clk) begin
		tid_q <= merged.tid;
		dat_q <= merged.dat;
	end

	always_comb begin
		resp_o.ack = ack_q;
		resp_o.err = err_q;
		resp_o.tid = tid_q;
		resp_o.dat = dat_q;
	end

	// OR merge is only valid with a single source at a time
	a_one_ack: assert property (@(posedge node_clk) disable iff (rst)
		$onehot0({scr_resp_i.ack, ioreg_resp_i.ack, cfg_ack, unm_ack}));

endmodule

`default_nettype wire

//--- soc_io_top.sv
`default_nettype none

module soc_io_top #(
	parameter int SCRATCH_WORDS = 256,
	parameter int TIMEOUT_CYCLES = 16,
	parameter int RST_PULSE_CYCLES = 64,
	parameter int TICK_DEFAULT = 200
) (
	input  wire logic                  node_clk,
	input  wire logic                  rst,
	input  wire soc_io_pkg::bus_req_t  req_i,
	output wire soc_io_pkg::bus_resp_t resp_o,
	output wire logic [7:0]            led_o,
	output wire logic [15:0]           rsts_o,
	output wire logic                  tick_irq_o
);
	import soc_io_pkg::*;

	logic        scr_start;
	logic        ioreg_start;
	logic        cfg_start;
	logic        unmapped_start;
	bus_resp_t   scr_resp;
	bus_resp_t   ioreg_resp;
	logic [15:0] tick_period;
	logic        tick_reload;

	// ------------------------------
	// decode
	// ------------------------------

	io_addr_decode u_decode (
		.node_clk         (node_clk),
		.rst              (rst),
		.req_i            (req_i),
		.scr_start_o      (scr_start),
		.ioreg_start_o    (ioreg_start),
		.cfg_start_o      (cfg_start),
		.unmapped_start_o (unmapped_start)
	);

	// ------------------------------
	// responders
	// ------------------------------

	scratch_ram #(
		.SCRATCH_WORDS (SCRATCH_WORDS)
	) u_scratch (
		.node_clk (node_clk),
		.rst      (rst),
		.start_i  (scr_start),
		.req_i    (req_i),
		.resp_o   (scr_resp)
	);

	io_regs #(
		.RST_PULSE_CYCLES (RST_PULSE_CYCLES),
		.TICK_DEFAULT     (TICK_DEFAULT)
	) u_regs (
		.node_clk      (node_clk),
		.rst           (rst),
		.start_i       (ioreg_start),
		.req_i         (req_i),
		.resp_o        (ioreg_resp),
		.led_o         (led_o),
		.rsts_o        (rsts_o),
		.tick_period_o (tick_period),
		.reload_o      (tick_reload)
	);

	// periodic interrupt, period set through the io page
	tick_timer u_tick (
		.node_clk      (node_clk),
		.rst           (rst),
		.tick_period_i (tick_period),
		.reload_i      (tick_reload),
		.tick_irq_o    (tick_irq_o)
	);

	// config timeout, bus error and response register
	resp_merge #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_merge (
		.node_clk         (node_clk),
		.rst              (rst),
		.req_i            (req_i),
		.scr_resp_i       (scr_resp),
		.ioreg_resp_i     (ioreg_resp),
		.cfg_start_i      (cfg_start),
		.unmapped_start_i (unmapped_start),
		.resp_o           (resp_o)
	);

endmodule

`default_nettype wire

//--- soc_io_checker.sv
`default_nettype none

module soc_io_checker #(
	parameter int SCRATCH_WORDS = 256,
	parameter int RST_PULSE_CYCLES = 64,
	parameter int TICK_DEFAULT = 200
) (
	input  wire logic                  node_clk,
	input  wire logic                  rst,
	input  wire soc_io_pkg::bus_req_t  req_i,
	input  wire logic [7:0]            exp_lat_i,
	input  wire logic                  exp_err_i,
	input  wire soc_io_pkg::bus_resp_t resp_i,
	input  wire logic [7:0]            led_i,
	input  wire logic [15:0]           rsts_i,
	input  wire logic                  tick_irq_i,
	input  wire logic                  end_i,
	output int                         error_count_o,
	output int                         check_count_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import soc_io_pkg::*;

	// model of the scratch words and the io registers
	logic [31:0] smem [SCRATCH_WORDS];
	logic [7:0]  led_m;
	logic [15:0] tick_m;

	// request in flight, latched when cyc rises
	int          cyc_n;
	logic        cyc_q;
	logic        pending;
	bus_req_t    held;
	int          start_n;
	int          lat_e;
	logic        err_e;

	// reset pulse and tick tracking
	logic        rst_active;
	logic [15:0] rst_val_m;
	int          rst_len;
	logic        tick_armed;
	int          next_tick;
	int          ticks_seen;
	logic        end_done;

	initial begin
		error_count_o = 0;
		check_count_o = 0;
	end

	// ------------------------------
	// helpers
	// ------------------------------

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count_o++;
		if (got !== exp) begin
			error_count_o++;
			$display("Error: %s got %h expected %h at cycle %0d", name, got, exp, cyc_n);
		end
	endtask

	task automatic report_fault(input string msg);
		error_count_o++;
		$display("%s (cycle %0d)", msg, cyc_n);
	endtask

	// owner of an address, scratch wins over io page and config
	function automatic io_chan_e target_of(input logic [31:0] padr);
		if (padr[31:24] == SCRATCH_PAGE)
			return CH_SCRATCH;
		if (padr[31:8] == IOREG_PAGE)
			return CH_IOREG;
		if (padr[31:28] == CONFIG_NIBBLE)
			return CH_CONFIG;
		return CH_UNMAPPED;
	endfunction

	// only the enabled bytes change
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] w;
		w = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				w[8*b +: 8] = new_w[8*b +: 8];
		end
		return w;
	endfunction

	// ------------------------------
	// per-target models
	// ------------------------------

	task automatic scratch_access;
		int idx;
		// word index wraps at the depth
		idx = int'(held.padr >> 2) % SCRATCH_WORDS;
		if (held.we)
			smem[idx] = merge_bytes(smem[idx], held.data, held.sel);
		else
			check_value("resp_o.dat", resp_i.dat, smem[idx]);
	endtask

	task automatic ioreg_access;
		logic [7:0]  ofs;
		logic [15:0] p;
		ofs = held.padr[7:0];
		if (held.we) begin
			if (ofs == IOREG_LED_OFS && held.sel[0]) begin
				led_m = held.data[7:0];
			end else if (ofs == IOREG_RST_OFS && (|held.sel[1:0])) begin
				// pulse already visible on the ack cycle
				rst_active = 1'b1;
				rst_val_m = held.data[15:0];
				rst_len = 0;
			end else if (ofs == IOREG_TICK_OFS && (|held.sel[1:0])) begin
				// zero period turns into one
				p = (held.data[15:0] == 16'd0) ? 16'd1 : held.data[15:0];
				tick_m = p;
				tick_armed = 1'b1;
				// first pulse one cycle short of a period after the bus ack
				next_tick = cyc_n + int'(p) - 1;
				ticks_seen = 0;
			end
		end else if (ofs == IOREG_LED_OFS)
			check_value("resp_o.dat", resp_i.dat, {24'd0, led_m});
		else if (ofs == IOREG_TICK_OFS)
			check_value("resp_o.dat", resp_i.dat, {16'd0, tick_m});
		else
			check_value("resp_o.dat", resp_i.dat, 32'd0);
	endtask

	task automatic handle_ack;
		check_value("ack latency", cyc_n - start_n, lat_e);
		check_value("resp_o.tid", resp_i.tid, held.tid);
		check_value("resp_o.err", resp_i.err, err_e);
		case (target_of(held.padr))
			CH_SCRATCH: scratch_access();
			CH_IOREG: ioreg_access();
			CH_CONFIG: begin
				if (!held.we)
					check_value("resp_o.dat", resp_i.dat, CONFIG_FILL);
			end
			default: ;
		endcase
		check_value("led_o", led_i, led_m);
	endtask

	// ------------------------------
	// output watchers
	// ------------------------------

	// pulse spacing against the last programmed period
	task automatic watch_tick;
		if (tick_armed) begin
			if (cyc_n == next_tick) begin
				check_value("tick_irq_o", tick_irq_i, 1);
				next_tick = next_tick + int'(tick_m);
				ticks_seen++;
			end else if (tick_irq_i)
				check_value("tick_irq_o", tick_irq_i, 0);
		end
	endtask

	task automatic watch_rst;
		if (rst_active) begin
			if (rsts_i == rst_val_m)
				rst_len++;
			else begin
				check_value("rsts_o", rsts_i, 0);
				check_value("reset pulse length", rst_len, RST_PULSE_CYCLES);
				rst_active = 1'b0;
			end
		end else if (rsts_i != 16'd0)
			check_value("rsts_o", rsts_i, 0);
	endtask

	task automatic final_checks;
		if (pending)
			report_fault("a request was still waiting for its ack at the end of the run");
		if (rst_active)
			report_fault("the reset pulse never returned to zero");
		if (!tick_armed || ticks_seen < 3)
			report_fault("fewer than three tick interrupts seen after the last period write");
	endtask

	// ------------------------------
	// sampling
	// ------------------------------

	// outputs change after the edge, so values here are from the last cycle
	always @(posedge node_clk) begin
		if (rst) begin
			cyc_n = 0;
			cyc_q = 1'b0;
			pending = 1'b0;
			led_m = 8'd0;
			tick_m = 16'(TICK_DEFAULT);
			rst_active = 1'b0;
			rst_len = 0;
			tick_armed = 1'b0;
			ticks_seen = 0;
			end_done = 1'b0;
		end else begin
			cyc_n++;
			if (resp_i.ack) begin
				if (!pending)
					report_fault("ack arrived with no request outstanding");
				else
					handle_ack();
				pending = 1'b0;
			end
			// timer already reloaded by a period write acked this cycle
			watch_tick();
			if (req_i.cyc && !cyc_q) begin
				if (pending)
					report_fault("new request started before the previous one was acked");
				pending = 1'b1;
				held = req_i;
				start_n = cyc_n;
				lat_e = int'(exp_lat_i);
				err_e = exp_err_i;
			end
			cyc_q = req_i.cyc;
			watch_rst();
			if (end_i && !end_done) begin
				final_checks();
				end_done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_soc_io.sv
`default_nettype none

module tb_soc_io;
	timeunit 1ns;
	timeprecision 100ps;
	import soc_io_pkg::*;

	localparam int SCRATCH_WORDS = 256;
	localparam int TIMEOUT_CYCLES = 16;
	localparam int RST_PULSE_CYCLES = 64;
	localparam int TICK_DEFAULT = 200;
	localparam logic [31:0] SEED = 32'h88691426;

	// cycles from cyc rising to ack, per target
	localparam int LAT_SCR = 4;
	localparam int LAT_REG = 3;
	localparam int LAT_UNM = 3;
	localparam int LAT_CFG = TIMEOUT_CYCLES + 2;
	// idle time at the end for the reset pulse and tick spacing
	localparam int DRAIN_CYCLES = 150;

	typedef struct packed {
		logic        we;
		logic [3:0]  sel;
		logic [31:0] padr;
		logic [31:0] data;
		logic [7:0]  tid;
		logic        exp_err;
		logic [7:0]  exp_lat;
	} entry_t;

	logic        node_clk;
	logic        rst;
	bus_req_t    req;
	bus_resp_t   resp;
	logic [7:0]  led;
	logic [15:0] rsts;
	logic        tick_irq;
	logic [7:0]  exp_lat;
	logic        exp_err;
	logic        end_run;
	int          error_count;
	int          check_count;
	int          cycle_n = 0;
	int          cycle_limit = 100000;
	entry_t      tbl[$];

	soc_io_top #(
		.SCRATCH_WORDS    (SCRATCH_WORDS),
		.TIMEOUT_CYCLES   (TIMEOUT_CYCLES),
		.RST_PULSE_CYCLES (RST_PULSE_CYCLES),
		.TICK_DEFAULT     (TICK_DEFAULT)
	) dut (
		.node_clk   (node_clk),
		.rst        (rst),
		.req_i      (req),
		.resp_o     (resp),
		.led_o      (led),
		.rsts_o     (rsts),
		.tick_irq_o (tick_irq)
	);

	soc_io_checker #(
		.SCRATCH_WORDS    (SCRATCH_WORDS),
		.RST_PULSE_CYCLES (RST_PULSE_CYCLES),
		.TICK_DEFAULT     (TICK_DEFAULT)
	) u_chk (
		.node_clk      (node_clk),
		.rst           (rst),
		.req_i         (req),
		.exp_lat_i     (exp_lat),
		.exp_err_i     (exp_err),
		.resp_i        (resp),
		.led_i         (led),
		.rsts_i        (rsts),
		.tick_irq_i    (tick_irq),
		.end_i         (end_run),
		.error_count_o (error_count),
		.check_count_o (check_count)
	);

	// 4 ns clock
	initial begin
		node_clk = 1'b0;
		forever #2 node_clk = ~node_clk;
	end

	task automatic print_counts;
		$display("errors: %0d  checks: %0d", error_count, check_count);
	endtask

	// watchdog on the whole run
	always @(posedge node_clk) begin
		cycle_n++;
		if (cycle_n > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			print_counts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ------------------------------
	// stimulus table
	// ------------------------------

	// tid follows the table position
	task automatic add_entry(input logic we, input logic [3:0] sel, input logic [31:0] padr,
		input logic [31:0] data, input int lat, input logic err);
		entry_t e;
		e.we = we;
		e.sel = sel;
		e.padr = padr;
		e.data = data;
		e.tid = 8'(tbl.size() + 1);
		e.exp_err = err;
		e.exp_lat = 8'(lat);
		tbl.push_back(e);
	endtask

	task automatic load_table;
		// scratch, full and partial writes then reads
		add_entry(1'b1, 4'hF, 32'hFF00_0010, $urandom(), LAT_SCR, 1'b0);
		add_entry(1'b1, 4'hF, 32'hFF00_0014, $urandom(), LAT_SCR, 1'b0);
		add_entry(1'b1, 4'h5, 32'hFF00_0010, $urandom(), LAT_SCR, 1'b0);
		add_entry(1'b1, 4'hA, 32'hFF00_0014, $urandom(), LAT_SCR, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFF00_0010, 32'd0, LAT_SCR, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFF00_0014, 32'd0, LAT_SCR, 1'b0);
		// word 256 wraps onto word 0
		add_entry(1'b1, 4'hF, 32'hFF00_0400, $urandom(), LAT_SCR, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFF00_0000, 32'd0, LAT_SCR, 1'b0);
		add_entry(1'b1, 4'hF, 32'hFF12_3448, $urandom(), LAT_SCR, 1'b0);
		add_entry(1'b1, 4'hC, 32'hFF12_3448, $urandom(), LAT_SCR, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFF12_3448, 32'd0, LAT_SCR, 1'b0);
		// io page, led, tick period, reset pulse, hole
		add_entry(1'b1, 4'h1, 32'hFEDF_FF00, 32'h0000_005A, LAT_REG, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFEDF_FF00, 32'd0, LAT_REG, 1'b0);
		add_entry(1'b1, 4'h3, 32'hFEDF_FF08, 32'd23, LAT_REG, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFEDF_FF08, 32'd0, LAT_REG, 1'b0);
		add_entry(1'b1, 4'h3, 32'hFEDF_FF04, 32'h0000_A5C3, LAT_REG, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFEDF_FF04, 32'd0, LAT_REG, 1'b0);
		add_entry(1'b1, 4'hF, 32'hFEDF_FF0C, 32'h0000_DEAD, LAT_REG, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFEDF_FF0C, 32'd0, LAT_REG, 1'b0);
		// config timeout, then bus errors
		add_entry(1'b0, 4'hF, 32'hD000_0000, 32'd0, LAT_CFG, 1'b0);
		add_entry(1'b0, 4'hF, 32'h1000_0000, 32'd0, LAT_UNM, 1'b1);
		add_entry(1'b1, 4'hF, 32'h2000_0040, 32'h1234_5678, LAT_UNM, 1'b1);
		// scratch still answers after an error
		add_entry(1'b0, 4'hF, 32'hFF00_0010, 32'd0, LAT_SCR, 1'b0);
		// zero period is stored as one, irq every cycle
		add_entry(1'b1, 4'h3, 32'hFEDF_FF08, 32'd0, LAT_REG, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFEDF_FF08, 32'd0, LAT_REG, 1'b0);
		// shorter period, restart of the tick count
		add_entry(1'b1, 4'h3, 32'hFEDF_FF08, 32'd11, LAT_REG, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFEDF_FF08, 32'd0, LAT_REG, 1'b0);
		add_entry(1'b1, 4'h1, 32'hFEDF_FF00, 32'h0000_00C3, LAT_REG, 1'b0);
		add_entry(1'b0, 4'hF, 32'hFEDF_FF00, 32'd0, LAT_REG, 1'b0);
	endtask

	// ------------------------------
	// driver
	// ------------------------------

	// called on a falling edge, returns on one with cyc low for a cycle
	task automatic run_entry(input entry_t e);
		req.cyc = 1'b1;
		req.we = e.we;
		req.sel = e.sel;
		req.tid = e.tid;
		req.padr = e.padr;
		req.data = e.data;
		exp_lat = e.exp_lat;
		exp_err = e.exp_err;
		@(negedge node_clk);
		while (!resp.ack)
			@(negedge node_clk);
		req = '0;
		@(negedge node_clk);
	endtask

	initial begin
		req = '0;
		exp_lat = 8'd0;
		exp_err = 1'b0;
		end_run = 1'b0;
		rst = 1'b1;
		void'($urandom(SEED));
		load_table();
		cycle_limit = tbl.size() * (TIMEOUT_CYCLES + 8) + 2000;
		repeat (4) @(posedge node_clk);
		@(negedge node_clk);
		rst = 1'b0;
		repeat (2) @(negedge node_clk);
		foreach (tbl[i])
			run_entry(tbl[i]);
		repeat (DRAIN_CYCLES) @(negedge node_clk);
		// checker closes its open items on the next edge
		end_run = 1'b1;
		@(negedge node_clk);
		print_counts();
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
soc_io_pkg.sv
io_addr_decode.sv
scratch_ram.sv
io_regs.sv
tick_timer.sv
resp_merge.sv
soc_io_top.sv
soc_io_checker.sv
tb_soc_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the io fabric testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_soc_io -f project.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
